//--- sdram_pkg.sv
package sdram_pkg;
    localparam int ADDR_W = 23;                 // Linear word address
    localparam int DATA_W = 16;                 // DQ width
    localparam int LEN_W = 9;                   // Burst length 1 to 256
    localparam int BANK_W = 2;
    localparam int ROW_W = 13;                  // Also the address pin count
    localparam int COL_W = 8;                   // 256 words per page

    localparam int CAS_LATENCY = 2;
    localparam int INIT_WAIT_CYCLES = 200;      // Short power-up wait for sim
    localparam int REFRESH_CYCLES = 390;        // Refresh request interval
    localparam int T_RP = 2;                    // Precharge to next command
    localparam int T_RCD = 2;                   // Activate to read or write
    localparam int T_RFC = 7;                   // Refresh to next command
    localparam int T_MRD = 2;                   // Load mode to next command

    localparam logic [1:0] CFG_ADDR_START = 2'd0;
    localparam logic [1:0] CFG_ADDR_LEN = 2'd1;
    localparam logic [1:0] CFG_ADDR_SEED = 2'd2;
    localparam logic [ADDR_W-1:0] DEFAULT_START = '0;
    localparam logic [LEN_W-1:0] DEFAULT_LEN = 9'd8;
    localparam logic [DATA_W-1:0] DEFAULT_SEED = 16'h5500;

    // Full page burst, sequential order, burst writes
    localparam logic [ROW_W-1:0] MODE_REG = {3'b000, 1'b0, 2'b00, 3'(CAS_LATENCY), 1'b0, 3'b111};

    // Controller FSM states
    localparam logic [3:0] ST_INIT_WAIT = 4'd0;
    localparam logic [3:0] ST_INIT_REF = 4'd1;
    localparam logic [3:0] ST_INIT_MODE = 4'd2;
    localparam logic [3:0] ST_IDLE = 4'd3;
    localparam logic [3:0] ST_WAIT = 4'd4;      // Command spacing
    localparam logic [3:0] ST_WRITE = 4'd5;
    localparam logic [3:0] ST_READ = 4'd6;
    localparam logic [3:0] ST_STOP = 4'd7;
    localparam logic [3:0] ST_PRECHARGE = 4'd8;

    typedef enum logic [3:0] {                  // {cs_n, ras_n, cas_n, we_n}
        NOP = 4'b0111,
        ACTIVE = 4'b0011,
        READ = 4'b0101,
        WRITE = 4'b0100,
        PRECHARGE = 4'b0010,
        AUTO_REFRESH = 4'b0001,
        LOAD_MODE = 4'b0000,
        BURST_STOP = 4'b0110
    } sdram_cmd_e;

    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } sdram_bac_t;

    typedef union packed {
        logic [ADDR_W-1:0] linear;              // Sequencer view
        sdram_bac_t bac;                        // Controller view
    } sdram_addr_u;
endpackage

//--- sdram_user_if.sv
interface sdram_user_if;
    logic wr_req;                               // Level until first wr_ack
    logic rd_req;                               // Level until first rd_ack
    sdram_pkg::sdram_addr_u wr_addr;
    sdram_pkg::sdram_addr_u rd_addr;
    logic [sdram_pkg::LEN_W-1:0] burst_len;     // Words per burst
    logic [sdram_pkg::DATA_W-1:0] wr_data;      // Next word after each wr_ack
    logic wr_ack;                               // One per word consumed
    logic rd_ack;                               // Marks valid rd_data
    logic [sdram_pkg::DATA_W-1:0] rd_data;
    logic init_done;

    modport seq (
        output wr_req, rd_req, wr_addr, rd_addr, burst_len, wr_data,
        input  wr_ack, rd_ack, rd_data, init_done
    );

    modport ctrl (
        input  wr_req, rd_req, wr_addr, rd_addr, burst_len, wr_data,
        output wr_ack, rd_ack, rd_data, init_done
    );
endinterface

//--- sdram_test_cfg.sv
module sdram_test_cfg (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    input  logic                             cfg_we,
    input  logic [1:0]                       cfg_addr,
    input  logic [sdram_pkg::ADDR_W-1:0]     cfg_wdata,
    output sdram_pkg::sdram_addr_u           start_addr,
    output logic [sdram_pkg::LEN_W-1:0]      burst_len,
    output logic [sdram_pkg::DATA_W-1:0]     seed
);
    logic [sdram_pkg::COL_W-1:0] len_low;       // Length modulo 256

    assign len_low = cfg_wdata[sdram_pkg::COL_W-1:0];

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            start_addr.linear <= sdram_pkg::DEFAULT_START;
            burst_len <= sdram_pkg::DEFAULT_LEN;
            seed <= sdram_pkg::DEFAULT_SEED;
        end else if (cfg_we) begin
            case (cfg_addr)
                sdram_pkg::CFG_ADDR_START: begin
                    start_addr.linear <= cfg_wdata;
                end
                sdram_pkg::CFG_ADDR_LEN: begin
                    burst_len <= {len_low == '0, len_low};  // Zero means a full page
                end
                sdram_pkg::CFG_ADDR_SEED: begin
                    seed <= cfg_wdata[sdram_pkg::DATA_W-1:0];
                end
                default: begin
                end                             // Index 3 unused
            endcase
        end
    end
endmodule

//--- test_sequencer.sv
module test_sequencer (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    input  logic                             start_n,
    input  sdram_pkg::sdram_addr_u           start_addr,
    input  logic [sdram_pkg::LEN_W-1:0]      burst_len,
    input  logic [sdram_pkg::DATA_W-1:0]     seed,
    sdram_user_if.seq                        mem,
    output logic                             test_done,
    output logic                             test_error,
    output logic [sdram_pkg::LEN_W-1:0]      error_count
);
    logic [1:0] step;                           // 0 idle, 1 write, 2 read back
    logic start_n_d;                            // For falling edge detect
    logic [sdram_pkg::LEN_W-1:0] cnt;           // Words done in this burst
    logic [sdram_pkg::DATA_W-1:0] exp_data;     // Running expected read word

    assign test_error = (error_count != '0);

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            step <= 2'd0;
            start_n_d <= 1'b1;
            cnt <= '0;
            test_done <= 1'b0;
            error_count <= '0;
            mem.wr_req <= 1'b0;
            mem.rd_req <= 1'b0;
        end else begin
            start_n_d <= start_n;
            case (step)
                2'd0: begin                     // Wait for start after init
                    if (start_n_d && !start_n && mem.init_done) begin
                        mem.wr_req <= 1'b1;
                        mem.wr_addr <= start_addr;
                        mem.burst_len <= burst_len;
                        mem.wr_data <= seed;
                        cnt <= '0;
                        error_count <= '0;      // Count covers one run only
                        test_done <= 1'b0;
                        step <= 2'd1;
                    end
                end
                2'd1: begin                     // Write burst
                    if (mem.wr_ack) begin
                        mem.wr_req <= 1'b0;
                        mem.wr_data <= mem.wr_data + 1'b1;
                        if (cnt == mem.burst_len - 1'b1) begin
                            cnt <= '0;
                            mem.rd_req <= 1'b1;     // Read back the same words
                            mem.rd_addr <= start_addr;
                            exp_data <= seed;
                            step <= 2'd2;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                2'd2: begin                     // Read back and compare
                    if (mem.rd_ack) begin
                        mem.rd_req <= 1'b0;
                        exp_data <= exp_data + 1'b1;
                        if (mem.rd_data != exp_data) begin
                            error_count <= error_count + 1'b1;
                        end
                        if (cnt == mem.burst_len - 1'b1) begin
                            test_done <= 1'b1;  // Held until next start
                            step <= 2'd0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    step <= 2'd0;
                end
            endcase
        end
    end
endmodule

//--- sdram_ctrl.sv
module sdram_ctrl (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    sdram_user_if.ctrl                       mem,
    output logic                             sdram_cke,
    output logic                             sdram_cs_n,
    output logic                             sdram_ras_n,
    output logic                             sdram_cas_n,
    output logic                             sdram_we_n,
    output logic [sdram_pkg::BANK_W-1:0]     sdram_ba,
    output logic [sdram_pkg::ROW_W-1:0]      sdram_addr,
    inout  wire  [sdram_pkg::DATA_W-1:0]     sdram_data
);
    logic [3:0] state;
    logic [3:0] nxt;                            // State after the spacing wait
    logic [sdram_pkg::LEN_W-1:0] cnt;           // Init wait, spacing and beats
    logic [sdram_pkg::LEN_W-1:0] len;           // Latched burst length
    logic [sdram_pkg::COL_W-1:0] col;           // Latched start column
    logic init_ref;                             // First init refresh issued
    sdram_pkg::sdram_cmd_e cmd;
    logic [$clog2(sdram_pkg::REFRESH_CYCLES)-1:0] ref_timer;
    logic ref_tick;
    logic ref_pend;
    logic [sdram_pkg::DATA_W-1:0] dq_out;
    logic dq_oe;
    logic [sdram_pkg::CAS_LATENCY+1:0] rd_vld;  // Read beat to rd_ack delay
    sdram_pkg::sdram_addr_u req_addr;

    assign req_addr = mem.wr_req ? mem.wr_addr : mem.rd_addr;
    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
    assign sdram_data = dq_oe ? dq_out : 'z;    // Driven only in write bursts
    assign mem.wr_ack = (state == sdram_pkg::ST_WRITE);
    assign mem.rd_ack = rd_vld[sdram_pkg::CAS_LATENCY+1];
    assign ref_tick = (ref_timer == sdram_pkg::REFRESH_CYCLES - 1);

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            ref_timer <= '0;
        end else if (ref_tick) begin
            ref_timer <= '0;
        end else begin
            ref_timer <= ref_timer + 1'b1;      // Free running
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= {rd_vld[sdram_pkg::CAS_LATENCY:0], state == sdram_pkg::ST_READ};
        end
    end

    always_ff @(posedge sys_clk) begin
        mem.rd_data <= sdram_data;              // DQ capture register
    end

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            state <= sdram_pkg::ST_INIT_WAIT;
            nxt <= sdram_pkg::ST_IDLE;
            cnt <= '0;
            cmd <= sdram_pkg::NOP;
            sdram_cke <= 1'b0;
            dq_oe <= 1'b0;
            init_ref <= 1'b0;
            ref_pend <= 1'b0;
            mem.init_done <= 1'b0;
        end else begin
            cmd <= sdram_pkg::NOP;              // NOP between commands
            case (state)
                sdram_pkg::ST_INIT_WAIT: begin
                    if (cnt == sdram_pkg::INIT_WAIT_CYCLES - 1) begin
                        sdram_cke <= 1'b1;
                        cmd <= sdram_pkg::PRECHARGE;
                        sdram_addr[10] <= 1'b1; // All banks
                        cnt <= sdram_pkg::LEN_W'(sdram_pkg::T_RP - 2);
                        nxt <= sdram_pkg::ST_INIT_REF;
                        state <= sdram_pkg::ST_WAIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sdram_pkg::ST_INIT_REF: begin   // Two refreshes
                    cmd <= sdram_pkg::AUTO_REFRESH;
                    init_ref <= 1'b1;
                    nxt <= init_ref ? sdram_pkg::ST_INIT_MODE : sdram_pkg::ST_INIT_REF;
                    cnt <= sdram_pkg::LEN_W'(sdram_pkg::T_RFC - 2);
                    state <= sdram_pkg::ST_WAIT;
                end
                sdram_pkg::ST_INIT_MODE: begin
                    cmd <= sdram_pkg::LOAD_MODE;
                    sdram_ba <= '0;
                    sdram_addr <= sdram_pkg::MODE_REG;
                    mem.init_done <= 1'b1;      // Requests wait out T_MRD in idle
                    cnt <= sdram_pkg::LEN_W'(sdram_pkg::T_MRD - 2);
                    nxt <= sdram_pkg::ST_IDLE;
                    state <= sdram_pkg::ST_WAIT;
                end
                sdram_pkg::ST_WAIT: begin
                    if (cnt == '0) begin
                        state <= nxt;           // Leaves cnt at zero for bursts
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                sdram_pkg::ST_IDLE: begin
                    if (ref_pend) begin         // Refresh before any request
                        cmd <= sdram_pkg::AUTO_REFRESH;
                        ref_pend <= 1'b0;
                        cnt <= sdram_pkg::LEN_W'(sdram_pkg::T_RFC - 2);
                        nxt <= sdram_pkg::ST_IDLE;
                        state <= sdram_pkg::ST_WAIT;
                    end else if (mem.wr_req || (mem.rd_req && rd_vld == '0)) begin
                        cmd <= sdram_pkg::ACTIVE;
                        sdram_ba <= req_addr.bac.bank;
                        sdram_addr <= req_addr.bac.row;
                        col <= req_addr.bac.col;
                        len <= mem.burst_len;
                        cnt <= sdram_pkg::LEN_W'(sdram_pkg::T_RCD - 2);
                        nxt <= mem.wr_req ? sdram_pkg::ST_WRITE : sdram_pkg::ST_READ;
                        state <= sdram_pkg::ST_WAIT;
                    end
                end
                sdram_pkg::ST_WRITE: begin      // One word per cycle
                    if (cnt == '0) begin
                        cmd <= sdram_pkg::WRITE;
                        sdram_addr <= sdram_pkg::ROW_W'(col);   // A10 low
                    end
                    dq_oe <= 1'b1;
                    dq_out <= mem.wr_data;
                    if (cnt == len - 1'b1) begin
                        state <= sdram_pkg::ST_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sdram_pkg::ST_READ: begin       // Beats feed rd_vld
                    if (cnt == '0) begin
                        cmd <= sdram_pkg::READ;
                        sdram_addr <= sdram_pkg::ROW_W'(col);
                    end
                    if (cnt == len - 1'b1) begin
                        state <= sdram_pkg::ST_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sdram_pkg::ST_STOP: begin       // Ends the full-page burst
                    cmd <= sdram_pkg::BURST_STOP;
                    dq_oe <= 1'b0;
                    state <= sdram_pkg::ST_PRECHARGE;
                end
                sdram_pkg::ST_PRECHARGE: begin
                    cmd <= sdram_pkg::PRECHARGE;
                    sdram_addr[10] <= 1'b1;
                    cnt <= sdram_pkg::LEN_W'(sdram_pkg::T_RP - 2);
                    nxt <= sdram_pkg::ST_IDLE;
                    state <= sdram_pkg::ST_WAIT;
                end
                default: begin
                    state <= sdram_pkg::ST_IDLE;
                end
            endcase
            if (ref_tick) begin
                ref_pend <= 1'b1;               // Wins over a same-cycle clear
            end
        end
    end
endmodule

//--- sdram_test.sv
module sdram_test (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    input  logic                             start_n,       // Falling level starts a run
    input  logic                             cfg_we,
    input  logic [1:0]                       cfg_addr,
    input  logic [sdram_pkg::ADDR_W-1:0]     cfg_wdata,
    output logic                             S_CKE,
    output logic                             S_NCS,
    output logic                             S_NWE,
    output logic                             S_NRAS,
    output logic                             S_NCAS,
    output logic [sdram_pkg::BANK_W-1:0]     S_BA,
    output logic [sdram_pkg::ROW_W-1:0]      S_A,
    inout  wire  [sdram_pkg::DATA_W-1:0]     S_DB,
    output logic                             test_done,
    output logic                             test_error,
    output logic [sdram_pkg::LEN_W-1:0]      error_count
);
    sdram_pkg::sdram_addr_u start_addr;         // Run settings
    logic [sdram_pkg::LEN_W-1:0] burst_len;
    logic [sdram_pkg::DATA_W-1:0] seed;

    sdram_user_if mem_if ();

    sdram_test_cfg cfg_i (
        .sys_clk     (sys_clk),
        .reset_n     (reset_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .start_addr  (start_addr),
        .burst_len   (burst_len),
        .seed        (seed)
    );

    test_sequencer seq_i (
        .sys_clk     (sys_clk),
        .reset_n     (reset_n),
        .start_n     (start_n),
        .start_addr  (start_addr),
        .burst_len   (burst_len),
        .seed        (seed),
        .mem         (mem_if.seq),
        .test_done   (test_done),
        .test_error  (test_error),
        .error_count (error_count)
    );

    sdram_ctrl ctrl_i (
        .sys_clk     (sys_clk),
        .reset_n     (reset_n),
        .mem         (mem_if.ctrl),
        .sdram_cke   (S_CKE),
        .sdram_cs_n  (S_NCS),
        .sdram_ras_n (S_NRAS),
        .sdram_cas_n (S_NCAS),
        .sdram_we_n  (S_NWE),
        .sdram_ba    (S_BA),
        .sdram_addr  (S_A),
        .sdram_data  (S_DB)
    );
endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic sys_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;          // 4 ns period
    end
endmodule

//--- sdram_model.sv
module sdram_model (
    input  logic                             sys_clk,
    input  logic                             cke,
    input  logic                             cs_n,
    input  logic                             ras_n,
    input  logic                             cas_n,
    input  logic                             we_n,
    input  logic [sdram_pkg::BANK_W-1:0]     ba,
    input  logic [sdram_pkg::ROW_W-1:0]      a,
    inout  wire  [sdram_pkg::DATA_W-1:0]     dq
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PIPE = sdram_pkg::CAS_LATENCY - 1;  // Edges from read beat to DQ update

    logic [sdram_pkg::DATA_W-1:0] mem [int];    // Sparse, keyed by linear address
    bit flip [int];                             // Words read back with one bit inverted
    sdram_pkg::sdram_cmd_e log_cmd [$];         // Every command but NOP
    int log_cyc [$];
    logic [sdram_pkg::ROW_W-1:0] log_a [$];
    int cyc = 0;
    sdram_pkg::sdram_cmd_e cmd;
    sdram_pkg::sdram_addr_u ptr;                // Bank, open row, burst column
    bit wr_burst = 1'b0;
    bit rd_burst = 1'b0;
    bit beat;
    logic [sdram_pkg::DATA_W-1:0] beat_data;
    bit pipe_vld [PIPE];
    logic [sdram_pkg::DATA_W-1:0] pipe_data [PIPE];
    bit dq_en = 1'b0;
    logic [sdram_pkg::DATA_W-1:0] dq_out;

    assign cmd = sdram_pkg::sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
    assign dq = dq_en ? dq_out : 'z;

    function automatic logic [sdram_pkg::DATA_W-1:0] peek(input int lin);
        if (mem.exists(lin)) begin
            return mem[lin];
        end
        return 16'(lin) ^ 16'(lin >> 7);        // Fill covers every address bit
    endfunction

    always @(posedge sys_clk) begin
        cyc <= cyc + 1;
        if (cke === 1'b1 && cs_n === 1'b0 && cmd != sdram_pkg::NOP) begin
            log_cmd.push_back(cmd);
            log_cyc.push_back(cyc);
            log_a.push_back(a);
            case (cmd)
                sdram_pkg::ACTIVE: begin
                    ptr.bac.bank = ba;
                    ptr.bac.row = a;
                end
                sdram_pkg::WRITE, sdram_pkg::READ: begin
                    ptr.bac.col = a[sdram_pkg::COL_W-1:0];
                    wr_burst = (cmd == sdram_pkg::WRITE);
                    rd_burst = (cmd == sdram_pkg::READ);
                end
                sdram_pkg::BURST_STOP, sdram_pkg::PRECHARGE: begin
                    wr_burst = 1'b0;
                    rd_burst = 1'b0;
                end
                default: begin
                end
            endcase
        end
        beat = 1'b0;
        if (wr_burst) begin
            mem[int'(ptr.linear)] = dq;         // Word sampled at the command edge too
            ptr.bac.col = ptr.bac.col + 1'b1;   // Full page wraps in the row
        end else if (rd_burst) begin
            beat = 1'b1;
            beat_data = peek(int'(ptr.linear));
            if (flip.exists(int'(ptr.linear))) begin
                beat_data[ptr.bac.col[3:0]] = ~beat_data[ptr.bac.col[3:0]];
            end
            ptr.bac.col = ptr.bac.col + 1'b1;
        end
        dq_en <= pipe_vld[PIPE-1];              // Valid CAS_LATENCY edges after READ
        dq_out <= pipe_data[PIPE-1];
        for (int i = PIPE - 1; i > 0; i--) begin
            pipe_vld[i] = pipe_vld[i-1];
            pipe_data[i] = pipe_data[i-1];
        end
        pipe_vld[0] = beat;
        pipe_data[0] = beat_data;
    end
endmodule

//--- sdram_test_props.sv
module sdram_test_props (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    input  logic                             cke,
    input  logic [3:0]                       cmd,           // {cs_n, ras_n, cas_n, we_n}
    input  logic                             dq_oe
);
    timeunit 1ns;
    timeprecision 100ps;

    logic row_open;                             // ACTIVE until PRECHARGE
    logic in_read;                              // READ until BURST_STOP
    logic any_cmd;                              // First command seen
    logic [3:0] since_act;                      // Saturating
    logic is_rw;

    assign is_rw = (cmd == sdram_pkg::READ) || (cmd == sdram_pkg::WRITE);

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            row_open <= 1'b0;
            in_read <= 1'b0;
            any_cmd <= 1'b0;
            since_act <= '1;
        end else begin
            if (cmd == sdram_pkg::ACTIVE) begin
                row_open <= 1'b1;
            end else if (cmd == sdram_pkg::PRECHARGE) begin
                row_open <= 1'b0;
            end
            if (cmd == sdram_pkg::READ) begin
                in_read <= 1'b1;
            end else if (cmd == sdram_pkg::BURST_STOP) begin
                in_read <= 1'b0;
            end
            if (cmd != sdram_pkg::NOP) begin
                any_cmd <= 1'b1;
            end
            if (cmd == sdram_pkg::ACTIVE) begin
                since_act <= 4'd1;
            end else if (since_act != '1) begin
                since_act <= since_act + 1'b1;
            end
        end
    end

    assert property (@(posedge sys_clk) disable iff (!reset_n) is_rw |-> row_open)
        else $error("READ or WRITE with no activated row");
    assert property (@(posedge sys_clk) disable iff (!reset_n)
        is_rw |-> since_act >= sdram_pkg::T_RCD)
        else $error("READ or WRITE too soon after ACTIVE");
    assert property (@(posedge sys_clk) disable iff (!reset_n)
        (in_read || cmd == sdram_pkg::READ) |-> !dq_oe)
        else $error("Controller drives DQ during a read burst");
    assert property (@(posedge sys_clk) disable iff (!reset_n)
        (!any_cmd && cmd == sdram_pkg::NOP) |-> !cke)
        else $error("CKE high before the first command");
endmodule

//--- tb_sdram_test.sv
module tb_sdram_test;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUNS = 15;                   // Default, 12 random, fault, full page
    localparam int IDLE_CYCLES = 3 * sdram_pkg::REFRESH_CYCLES;
    localparam int RUN_CYCLES = 2 * 256 + sdram_pkg::REFRESH_CYCLES + 40;
    localparam int LIMIT = sdram_pkg::INIT_WAIT_CYCLES + 600 + IDLE_CYCLES + RUNS * RUN_CYCLES;
    localparam int REF_BOUND = sdram_pkg::REFRESH_CYCLES + 256 + sdram_pkg::T_RCD
                               + sdram_pkg::T_RP + sdram_pkg::CAS_LATENCY;

    logic sys_clk;
    logic reset_n = 1'b0;
    logic start_n = 1'b1;
    logic cfg_we = 1'b0;
    logic [1:0] cfg_addr = 2'd0;
    logic [sdram_pkg::ADDR_W-1:0] cfg_wdata = '0;
    wire s_cke;
    wire s_ncs;
    wire s_nwe;
    wire s_nras;
    wire s_ncas;
    wire [sdram_pkg::BANK_W-1:0] s_ba;
    wire [sdram_pkg::ROW_W-1:0] s_a;
    wire [sdram_pkg::DATA_W-1:0] s_db;
    wire test_done;
    wire test_error;
    wire [sdram_pkg::LEN_W-1:0] error_count;
    logic [sdram_pkg::DATA_W-1:0] ref_mem [int];    // Words the runs have written
    int data_errs = 0;
    int log_errs = 0;
    int cycles = 0;

    tb_clk_gen clk_i (.sys_clk(sys_clk));

    sdram_test sdram_test_i (
        .sys_clk(sys_clk), .reset_n(reset_n), .start_n(start_n),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .S_CKE(s_cke), .S_NCS(s_ncs), .S_NWE(s_nwe), .S_NRAS(s_nras), .S_NCAS(s_ncas),
        .S_BA(s_ba), .S_A(s_a), .S_DB(s_db),
        .test_done(test_done), .test_error(test_error), .error_count(error_count)
    );

    sdram_model model_i (
        .sys_clk(sys_clk), .cke(s_cke), .cs_n(s_ncs), .ras_n(s_nras), .cas_n(s_ncas),
        .we_n(s_nwe), .ba(s_ba), .a(s_a), .dq(s_db)
    );

    bind sdram_test sdram_test_props props_i (
        .sys_clk(sys_clk), .reset_n(reset_n), .cke(S_CKE),
        .cmd({S_NCS, S_NRAS, S_NCAS, S_NWE}), .dq_oe(ctrl_i.dq_oe)
    );

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, a run never finished", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [sdram_pkg::DATA_W-1:0] fill_word(input int lin);
        return 16'(lin) ^ 16'(lin >> 7);        // Unwritten words in the model
    endfunction

    function automatic logic [sdram_pkg::DATA_W-1:0] expect_word(input int lin);
        if (ref_mem.exists(lin)) begin
            return ref_mem[lin];
        end
        return fill_word(lin);
    endfunction

    function automatic int word_addr(input int start, input int k);
        return (start & ~255) | ((start + k) & 255);    // Column wraps inside the row
    endfunction

    task automatic report_fail(input bit in_log, input string msg);
        if (in_log) begin
            log_errs++;
        end else begin
            data_errs++;
        end
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input int lin);
        logic [sdram_pkg::DATA_W-1:0] got;
        got = model_i.peek(lin);
        if (got !== expect_word(lin)) begin
            report_fail(1'b0, $sformatf("word %06h holds %04h, expected %04h",
                                        lin, got, expect_word(lin)));
        end
    endtask

    task automatic write_cfg(input logic [1:0] idx, input int data);
        @(negedge sys_clk);
        cfg_we = 1'b1;
        cfg_addr = idx;
        cfg_wdata = sdram_pkg::ADDR_W'(data);
        @(negedge sys_clk);
        cfg_we = 1'b0;
    endtask

    task automatic run_test(input int start, input int len, input int seed, input int faults,
                            input bit configure);
        if (configure) begin
            write_cfg(sdram_pkg::CFG_ADDR_START, start);
            write_cfg(sdram_pkg::CFG_ADDR_LEN, len & 255);  // 256 goes in as zero
            write_cfg(sdram_pkg::CFG_ADDR_SEED, seed);
        end
        model_i.flip.delete();
        while (model_i.flip.size() < faults) begin   // Distinct words inside the burst
            model_i.flip[word_addr(start, int'($urandom_range(len - 1, 0)))] = 1'b1;
        end
        @(negedge sys_clk);
        start_n = 1'b0;
        @(negedge sys_clk);                     // Sequencer clears test_done here
        start_n = 1'b1;
        while (!test_done) begin
            @(negedge sys_clk);
        end
        for (int k = 0; k < len; k++) begin
            ref_mem[word_addr(start, k)] = 16'(seed + k);
        end
        if (error_count != sdram_pkg::LEN_W'(faults)) begin
            report_fail(1'b0, $sformatf("error_count %0d, expected %0d", error_count, faults));
        end
        if (test_error != (faults != 0)) begin
            report_fail(1'b0, $sformatf("test_error %0b with %0d faults", test_error, faults));
        end
        for (int k = -1; k <= len; k++) begin  // Burst plus a word on each side
            check_word(word_addr(start, k));
        end
        check_word(((start & ~255) - 1) & 32'h7fffff);  // Neighbouring rows untouched
        check_word(((start | 255) + 1) & 32'h7fffff);
    endtask

    task automatic check_init_log();
        if (model_i.log_cmd[0] != sdram_pkg::PRECHARGE || model_i.log_a[0][10] !== 1'b1) begin
            report_fail(1'b1, "first command is not precharge-all");
        end
        if (model_i.log_cyc[0] < sdram_pkg::INIT_WAIT_CYCLES) begin
            report_fail(1'b1, $sformatf("first command at cycle %0d", model_i.log_cyc[0]));
        end
        if (model_i.log_cmd[1] != sdram_pkg::AUTO_REFRESH ||
            model_i.log_cmd[2] != sdram_pkg::AUTO_REFRESH) begin
            report_fail(1'b1, "init does not issue two refreshes");
        end
        if (model_i.log_cmd[3] != sdram_pkg::LOAD_MODE ||
            model_i.log_a[3][6:4] != 3'(sdram_pkg::CAS_LATENCY) ||
            model_i.log_a[3][2:0] != 3'b111) begin
            report_fail(1'b1, "load-mode missing or wrong CAS latency or burst");
        end
    endtask

    task automatic check_refresh_gaps();
        int last;
        last = -1;
        for (int i = 0; i < model_i.log_cmd.size(); i++) begin
            if (model_i.log_cmd[i] == sdram_pkg::AUTO_REFRESH) begin
                if (last >= 0 && model_i.log_cyc[i] - last > REF_BOUND) begin
                    report_fail(1'b1, $sformatf("refresh gap of %0d cycles at cycle %0d",
                                                model_i.log_cyc[i] - last, model_i.log_cyc[i]));
                end
                last = model_i.log_cyc[i];
            end
        end
        if (model_i.cyc - last > REF_BOUND) begin
            report_fail(1'b1, $sformatf("no refresh since cycle %0d", last));
        end
    endtask

    initial begin
        int start;
        int len;
        void'($urandom(8));                     // Single seed for the whole run
        repeat (8) @(negedge sys_clk);
        reset_n = 1'b1;
        if (test_done !== 1'b0 || test_error !== 1'b0 || error_count !== '0) begin
            report_fail(1'b0, "status outputs not clear after reset");
        end
        if ({s_ncs, s_nras, s_ncas, s_nwe} !== sdram_pkg::NOP || s_cke !== 1'b0 ||
            s_db !== 16'hzzzz || model_i.log_cmd.size() != 0) begin
            report_fail(1'b1, "pins not idle after reset");
        end
        while (model_i.log_cmd.size() < 4) begin
            @(negedge sys_clk);
        end
        check_init_log();
        run_test(0, 8, 16'h5500, 0, 1'b0);      // Reset defaults, no writes
        for (int r = 0; r < 12; r++) begin
            start = $urandom & 32'h7fffff;
            len = $urandom_range(256, 1);
            if (r % 2 == 1) begin
                start = (start & ~255) | ((256 - len / 2) & 255);   // Crosses the row end
            end
            run_test(start, len, $urandom & 32'hffff, 0, 1'b1);
        end
        start = $urandom & 32'h7fffff;
        len = $urandom_range(64, 8);
        run_test(start, len, $urandom & 32'hffff, $urandom_range(4, 1), 1'b1);
        run_test($urandom & 32'h7fffff, 256, $urandom & 32'hffff, 0, 1'b1);
        repeat (IDLE_CYCLES) @(negedge sys_clk);   // Refresh goes on while idle
        check_refresh_gaps();
        $display("Errors: %0d in data and status, %0d in the command log", data_errs, log_errs);
        if (data_errs == 0 && log_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end
endmodule

//--- sdram_test.f
sdram_pkg.sv
sdram_user_if.sv
sdram_test_cfg.sv
test_sequencer.sv
sdram_ctrl.sv
sdram_test.sv
tb_clk_gen.sv
sdram_model.sv
sdram_test_props.sv
tb_sdram_test.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM test simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_test \
    -f sdram_test.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
